// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --top-module tb_fpga_top -f verilog.f -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -qF "*** PASSED ***" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: controller_regs.sv
`timescale 1ns/1ps
`include "fpga_consts.svh"

module controller_regs import fpga_pkg::*; (
  input logic CPU_CKIO,
  input logic rst_n,
  input logic cpu_cs_n,
  input logic cpu_we_n,
  input logic [1:0] cpu_select,
  input logic [13:0] cpu_addr,
  input logic [15:0] cpu_data,
  output mod_cfg_t mod_cfg,
  output logic gain_rd_segment,
  output bus_wr_t mod_wr,
  output bus_wr_t gain_wr,
  output logic mod_wr_valid,
  output logic gain_wr_valid
);

  logic we_n_q;
  logic wr_edge;
  logic wr_valid;
  bus_wr_t wr_q;
  logic [1:0] ctl_flag;
  logic mod_wr_segment;
  logic [15:0] mod_cycle;
  logic [15:0] mod_freq_div;

  // previous we level for edge detect
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      we_n_q <= 1'b1;
      wr_valid <= 1'b0;
    end else begin
      we_n_q <= cpu_we_n;
      wr_valid <= wr_edge;
    end
  end

  // we falling while cs held low
  assign wr_edge = ~cpu_cs_n & we_n_q & ~cpu_we_n;

  // bus is stable across the we pulse
  always_ff @(posedge CPU_CKIO) begin
    if (wr_edge) begin
      wr_q <= '{select: cpu_select, addr: cpu_addr, data: cpu_data};
    end
  end

  // register page
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      ctl_flag <= 2'b00;
      mod_wr_segment <= 1'b0;
      mod_cycle <= 16'd0;
      mod_freq_div <= 16'd1;
    end else if (wr_valid && wr_q.select == `BRAM_SELECT_CONTROLLER) begin
      case (wr_q.addr)
        `ADDR_CTL_FLAG: ctl_flag <= wr_q.data[1:0];
        `ADDR_MOD_MEM_WR_SEGMENT: mod_wr_segment <= wr_q.data[0];
        `ADDR_MOD_CYCLE: mod_cycle <= wr_q.data;
        `ADDR_MOD_FREQ_DIV: mod_freq_div <= wr_q.data;
        default: ;
      endcase
    end
  end

  assign mod_cfg.cycle = mod_cycle;
  assign mod_cfg.freq_div = mod_freq_div;
  assign mod_cfg.rd_segment = ctl_flag[`CTL_FLAG_MOD_SEGMENT_BIT];
  assign mod_cfg.wr_segment = mod_wr_segment;
  assign gain_rd_segment = ctl_flag[`CTL_FLAG_GAIN_SEGMENT_BIT];

  // memory writes share the decoded payload
  assign mod_wr = wr_q;
  assign gain_wr = wr_q;
  assign mod_wr_valid = wr_valid && (wr_q.select == `BRAM_SELECT_MOD);
  assign gain_wr_valid = wr_valid && (wr_q.select == `BRAM_SELECT_NORMAL);

  // each bus write lands in one place only
  a_one_dest: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    !(mod_wr_valid && gain_wr_valid));

endmodule

// File: fpga_consts.svh
`ifndef FPGA_CONSTS_SVH
`define FPGA_CONSTS_SVH

// transducers in the array, also one frame length
`define TRANS_NUM 249

// bram select codes on cpu_addr upper bits
`define BRAM_SELECT_CONTROLLER 2'd0
`define BRAM_SELECT_MOD 2'd1
`define BRAM_SELECT_NORMAL 2'd2

// controller register page
`define ADDR_CTL_FLAG 14'h0000
`define ADDR_MOD_MEM_WR_SEGMENT 14'h0020
`define ADDR_MOD_CYCLE 14'h0022
`define ADDR_MOD_FREQ_DIV 14'h0023

// ctl flag bits
`define CTL_FLAG_MOD_SEGMENT_BIT 0
`define CTL_FLAG_GAIN_SEGMENT_BIT 1

// words per mod segment, two byte samples each
`define MOD_WORDS 256

`endif

// File: fpga_pkg.sv
package fpga_pkg;

  // one decoded cpu bus write
  typedef struct packed {
    logic [1:0] select;
    logic [13:0] addr;
    logic [15:0] data;
  } bus_wr_t;

  // gain table entry, upper byte intensity
  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } gain_t;

  // modulation settings from the register page
  typedef struct packed {
    // last sample index
    logic [15:0] cycle;
    // clocks per sample, 0 behaves as 1
    logic [15:0] freq_div;
    logic rd_segment;
    logic wr_segment;
  } mod_cfg_t;

  // per-transducer drive word
  typedef struct packed {
    logic [7:0] idx;
    logic [7:0] intensity;
    logic [7:0] phase;
  } drive_t;

endpackage

// File: fpga_top.sv
`timescale 1ns/1ps

module fpga_top import fpga_pkg::*; (
  input logic CPU_CKIO,
  input logic rst_n,
  input logic cpu_cs_n,
  input logic cpu_we_n,
  input logic [1:0] cpu_select,
  input logic [13:0] cpu_addr,
  input logic [15:0] cpu_data,
  output drive_t dout,
  output logic dout_valid
);

  mod_cfg_t mod_cfg;
  logic gain_rd_segment;
  bus_wr_t mod_wr;
  bus_wr_t gain_wr;
  logic mod_wr_valid;
  logic gain_wr_valid;
  logic frame_start;
  logic [7:0] mod_value;
  drive_t gain_out;
  logic gain_valid;

  // cpu bus decode and register page
  controller_regs u_controller_regs (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .cpu_cs_n(cpu_cs_n),
    .cpu_we_n(cpu_we_n),
    .cpu_select(cpu_select),
    .cpu_addr(cpu_addr),
    .cpu_data(cpu_data),
    .mod_cfg(mod_cfg),
    .gain_rd_segment(gain_rd_segment),
    .mod_wr(mod_wr),
    .gain_wr(gain_wr),
    .mod_wr_valid(mod_wr_valid),
    .gain_wr_valid(gain_wr_valid)
  );

  // modulation, updated once per frame
  mod_sampler u_mod_sampler (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .mod_cfg(mod_cfg),
    .mod_wr(mod_wr),
    .mod_wr_valid(mod_wr_valid),
    .frame_start(frame_start),
    .mod_value(mod_value)
  );

  gain_reader u_gain_reader (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .gain_rd_segment(gain_rd_segment),
    .gain_wr(gain_wr),
    .gain_wr_valid(gain_wr_valid),
    .gain_out(gain_out),
    .gain_valid(gain_valid),
    .frame_start(frame_start)
  );

  intensity_modulator u_intensity_modulator (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .gain_in(gain_out),
    .gain_valid(gain_valid),
    .mod_value(mod_value),
    .dout(dout),
    .dout_valid(dout_valid)
  );

endmodule

// File: gain_reader.sv
`timescale 1ns/1ps
`include "fpga_consts.svh"

module gain_reader import fpga_pkg::*; (
  input logic CPU_CKIO,
  input logic rst_n,
  input logic gain_rd_segment,
  input bus_wr_t gain_wr,
  input logic gain_wr_valid,
  output drive_t gain_out,
  output logic gain_valid,
  output logic frame_start
);

  logic [7:0] rd_idx;
  logic last_idx;
  logic rd_seg_q;
  logic [7:0] idx_q;
  gain_t rd_gain;

  assign last_idx = (rd_idx == 8'(`TRANS_NUM - 1));

  // frame sweep, one transducer per clock
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      rd_idx <= 8'd0;
    end else if (last_idx) begin
      rd_idx <= 8'd0;
    end else begin
      rd_idx <= rd_idx + 8'd1;
    end
  end

  // segment only changes at a frame boundary
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      rd_seg_q <= 1'b0;
    end else if (last_idx) begin
      rd_seg_q <= gain_rd_segment;
    end
  end

  // marks the read of index 0
  assign frame_start = (rd_idx == 8'd0);

  // address bit 8 picks the segment
  seg_ram #(
    .T(gain_t),
    .DEPTH(`TRANS_NUM)
  ) u_gain_ram (
    .CPU_CKIO(CPU_CKIO),
    .wr_en(gain_wr_valid),
    .wr_seg(gain_wr.addr[8]),
    .wr_addr(gain_wr.addr[7:0]),
    .wr_data(gain_wr.data),
    .rd_seg(rd_seg_q),
    .rd_addr(rd_idx),
    .rd_data(rd_gain)
  );

  // index delayed to line up with ram data
  always_ff @(posedge CPU_CKIO) begin
    idx_q <= rd_idx;
  end

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      gain_valid <= 1'b0;
    end else begin
      gain_valid <= 1'b1;
    end
  end

  always_comb begin
    gain_out.idx = idx_q;
    gain_out.intensity = rd_gain.intensity;
    gain_out.phase = rd_gain.phase;
  end

endmodule

// File: intensity_modulator.sv
`timescale 1ns/1ps

module intensity_modulator import fpga_pkg::*; (
  input logic CPU_CKIO,
  input logic rst_n,
  input drive_t gain_in,
  input logic gain_valid,
  input logic [7:0] mod_value,
  output drive_t dout,
  output logic dout_valid
);

  logic [8:0] mod_scale;
  logic [15:0] product;

  // m + 1 so full scale passes intensity unchanged
  assign mod_scale = {1'b0, mod_value} + 9'd1;

  // 255 * 256 still fits in 16 bits
  assign product = 16'(gain_in.intensity) * 16'(mod_scale);

  // output stage, phase and index pass through
  always_ff @(posedge CPU_CKIO) begin
    dout.idx <= gain_in.idx;
    dout.intensity <= product[15:8];
    dout.phase <= gain_in.phase;
  end

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= gain_valid;
    end
  end

endmodule

// File: mod_sampler.sv
`timescale 1ns/1ps
`include "fpga_consts.svh"

module mod_sampler import fpga_pkg::*; (
  input logic CPU_CKIO,
  input logic rst_n,
  input mod_cfg_t mod_cfg,
  input bus_wr_t mod_wr,
  input logic mod_wr_valid,
  input logic frame_start,
  output logic [7:0] mod_value
);

  logic [15:0] div_last;
  logic [15:0] div_cnt;
  logic tick;
  logic [15:0] sample_idx;
  logic [15:0] rd_word;
  logic byte_sel_q;
  logic [7:0] sample_q;

  // freq_div of 0 runs like 1
  assign div_last = (mod_cfg.freq_div == 16'd0) ? 16'd0 : mod_cfg.freq_div - 16'd1;
  assign tick = (div_cnt >= div_last);

  // sample timer
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      div_cnt <= 16'd0;
    end else if (tick) begin
      div_cnt <= 16'd0;
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  // sample index, wraps after cycle
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      sample_idx <= 16'd0;
    end else if (tick) begin
      if (sample_idx >= mod_cfg.cycle) begin
        sample_idx <= 16'd0;
      end else begin
        sample_idx <= sample_idx + 16'd1;
      end
    end
  end

  // two samples per word, even index in the low byte
  seg_ram #(
    .T(logic [15:0]),
    .DEPTH(`MOD_WORDS)
  ) u_mod_ram (
    .CPU_CKIO(CPU_CKIO),
    .wr_en(mod_wr_valid),
    .wr_seg(mod_cfg.wr_segment),
    .wr_addr(mod_wr.addr[7:0]),
    .wr_data(mod_wr.data),
    .rd_seg(mod_cfg.rd_segment),
    .rd_addr(sample_idx[8:1]),
    .rd_data(rd_word)
  );

  // byte select follows the ram latency, then one more stage
  always_ff @(posedge CPU_CKIO) begin
    byte_sel_q <= sample_idx[0];
    sample_q <= byte_sel_q ? rd_word[15:8] : rd_word[7:0];
  end

  // value held for a whole frame
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      mod_value <= 8'd0;
    end else if (frame_start) begin
      mod_value <= sample_q;
    end
  end

  // cycle must keep the index inside the sample memory
  a_idx_range: assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
    sample_idx < 16'(2 * `MOD_WORDS));

endmodule

// File: seg_ram.sv
`timescale 1ns/1ps

module seg_ram import fpga_pkg::*; #(
  parameter type T = gain_t,
  parameter int DEPTH = 256
) (
  input logic CPU_CKIO,
  input logic wr_en,
  input logic wr_seg,
  input logic [7:0] wr_addr,
  input T wr_data,
  input logic rd_seg,
  input logic [7:0] rd_addr,
  output T rd_data
);

  // two segments, written and read independently
  T mem [2][DEPTH];

  // single write port
  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[wr_seg][wr_addr] <= wr_data;
    end
  end

  // registered read, one clock latency
  always_ff @(posedge CPU_CKIO) begin
    rd_data <= mem[rd_seg][rd_addr];
  end

  // writer must stay inside the segment
  a_wr_range: assert property (@(posedge CPU_CKIO)
    wr_en |-> (int'(wr_addr) < DEPTH));

endmodule

// File: tb_fpga_tasks.svh
`ifndef TB_FPGA_TASKS_SVH
`define TB_FPGA_TASKS_SVH

// xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// intensity * (m + 1) / 256
function automatic logic [7:0] scaled(input logic [7:0] i, input logic [7:0] m);
  return 8'((int'(i) * (int'(m) + 1)) / 256);
endfunction

// true when the whole captured frame is segment seg scaled by m
function automatic bit frame_matches(input logic seg, input logic [7:0] m);
  bit ok;
  ok = 1'b1;
  for (int k = 0; k < `TRANS_NUM; k++) begin
    if (cap_int[k] != scaled(exp_int[seg][k], m) || cap_ph[k] != exp_ph[seg][k]) begin
      ok = 1'b0;
    end
  end
  return ok;
endfunction

// reset low for 8 clocks, dout_valid must stay low
task automatic hold_reset();
  repeat (8) begin
    @(negedge CPU_CKIO);
    n_checks++;
    assert (!dout_valid) else begin
      n_errors++;
      $display("Mismatch at %0t: dout_valid got %0b expected 0", $time, dout_valid);
    end
  end
  rst_n = 1'b1;
endtask

// cs low, we low one clock later for two clocks, then release
task automatic bus_write(input logic [1:0] sel, input logic [13:0] addr,
    input logic [15:0] data);
  @(negedge CPU_CKIO);
  cpu_select = sel;
  cpu_addr = addr;
  cpu_data = data;
  cpu_cs_n = 1'b0;
  @(negedge CPU_CKIO);
  cpu_we_n = 1'b0;
  repeat (2) @(negedge CPU_CKIO);
  cpu_we_n = 1'b1;
  @(negedge CPU_CKIO);
  cpu_cs_n = 1'b1;
endtask

// random gains into one segment, segment 1 differs in every intensity
task automatic load_gains(input logic seg);
  logic [7:0] gi;
  for (int i = 0; i < `TRANS_NUM; i++) begin
    rng_state = xorshift32(rng_state);
    gi = (seg && rng_state[15:8] == exp_int[0][i]) ? ~rng_state[15:8] : rng_state[15:8];
    exp_int[seg][i] = gi;
    exp_ph[seg][i] = rng_state[7:0];
    bus_write(`BRAM_SELECT_NORMAL, {5'd0, seg, 8'(i)}, {gi, rng_state[7:0]});
  end
endtask

// wait up to limit clocks for index 0, then record one frame
task automatic capture_frame(input int limit);
  int guard;
  guard = 0;
  @(negedge CPU_CKIO);
  while (!(dout_valid && dout.idx == 8'd0) && guard < limit) begin
    @(negedge CPU_CKIO);
    guard++;
  end
  if (!(dout_valid && dout.idx == 8'd0)) begin
    timed_out = 1'b1;
    n_errors++;
    $display("timeout at %0t: no frame start on dout within %0d clocks", $time, limit);
    return;
  end
  for (int k = 0; k < `TRANS_NUM; k++) begin
    if (k > 0) begin
      @(negedge CPU_CKIO);
    end
    n_checks++;
    assert (dout_valid) else begin
      n_errors++;
      $display("Mismatch at %0t: dout_valid got 0 expected 1", $time);
    end
    cap_int[k] = dout.intensity;
    cap_ph[k] = dout.phase;
  end
endtask

// first frame may straddle the last write
task automatic capture_settled_frame();
  capture_frame(2 * `TRANS_NUM);
  if (!timed_out) begin
    capture_frame(2 * `TRANS_NUM);
  end
endtask

task automatic check_frame(input logic seg, input logic [7:0] m);
  logic [15:0] want;
  for (int k = 0; k < `TRANS_NUM; k++) begin
    want = {scaled(exp_int[seg][k], m), exp_ph[seg][k]};
    n_checks++;
    assert ({cap_int[k], cap_ph[k]} == want) else begin
      n_errors++;
      $display("Mismatch at %0t: dout[%0d] intensity,phase got %h expected %h",
        $time, k, {cap_int[k], cap_ph[k]}, want);
    end
  end
endtask

task automatic test_frame_order();
  capture_frame(`TRANS_NUM + 3);
  if (!timed_out) begin
    capture_frame(`TRANS_NUM + 3);
  end
endtask

// full scale modulation shows the table unchanged
task automatic test_pass_through();
  if (timed_out) return;
  for (int w = 0; w < `MOD_WORDS; w++) begin
    bus_write(`BRAM_SELECT_MOD, 14'(w), 16'hffff);
  end
  load_gains(1'b0);
  capture_settled_frame();
  if (!timed_out) check_frame(1'b0, 8'hff);
endtask

// cycle is 0, so word 0 low byte drives every frame
task automatic test_scaling();
  logic [7:0] mods [2];
  mods[0] = 8'h5a;
  mods[1] = 8'h00;
  for (int n = 0; n < 2; n++) begin
    if (timed_out) return;
    // high byte differs so a swapped byte select shows up
    bus_write(`BRAM_SELECT_MOD, 14'd0, {~mods[n], mods[n]});
    capture_settled_frame();
    if (!timed_out) check_frame(1'b0, mods[n]);
  end
endtask

// samples 0x40 and 0xc0, one sample per frame length
task automatic test_mod_stepping();
  int n_a;
  int n_b;
  bit is_a;
  bit is_b;
  n_a = 0;
  n_b = 0;
  if (timed_out) return;
  bus_write(`BRAM_SELECT_MOD, 14'd0, 16'hc040);
  bus_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_FREQ_DIV, 16'(`TRANS_NUM));
  bus_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'd1);
  capture_frame(2 * `TRANS_NUM);
  for (int f = 0; f < 4; f++) begin
    capture_frame(2 * `TRANS_NUM);
    if (timed_out) return;
    is_a = frame_matches(1'b0, 8'h40);
    is_b = frame_matches(1'b0, 8'hc0);
    n_a = n_a + int'(is_a);
    n_b = n_b + int'(is_b);
    n_checks++;
    assert (is_a || is_b) else begin
      n_errors++;
      $display("frame %0d ending at %0t is not scaled uniformly by either sample", f, $time);
    end
  end
  n_checks++;
  assert (n_a > 0 && n_b > 0) else begin
    n_errors++;
    $display("modulation did not step: %0d frames with 0x40, %0d with 0xc0", n_a, n_b);
  end
  // back to one full scale sample
  bus_write(`BRAM_SELECT_CONTROLLER, `ADDR_MOD_CYCLE, 16'd0);
  bus_write(`BRAM_SELECT_MOD, 14'd0, 16'hffff);
endtask

// segment 1 loads in the background, flag bit 1 flips the reader
task automatic test_segment_switch();
  if (timed_out) return;
  load_gains(1'b1);
  capture_frame(2 * `TRANS_NUM);
  if (timed_out) return;
  check_frame(1'b0, 8'hff);
  bus_write(`BRAM_SELECT_CONTROLLER, `ADDR_CTL_FLAG, 16'h0002);
  capture_settled_frame();
  if (!timed_out) check_frame(1'b1, 8'hff);
endtask

`endif

// File: tb_fpga_top.sv
`timescale 1ns/1ps
`include "fpga_consts.svh"

module tb_fpga_top import fpga_pkg::*; ();

  logic CPU_CKIO;
  logic rst_n;
  logic cpu_cs_n;
  logic cpu_we_n;
  logic [1:0] cpu_select;
  logic [13:0] cpu_addr;
  logic [15:0] cpu_data;
  drive_t dout;
  logic dout_valid;

  int n_checks;
  int n_errors;
  // a wait ran out, remaining tests are skipped
  bit timed_out;
  logic [31:0] rng_state;
  // expected gain tables per segment
  logic [7:0] exp_int [2][`TRANS_NUM];
  logic [7:0] exp_ph [2][`TRANS_NUM];
  // last captured output frame
  logic [7:0] cap_int [`TRANS_NUM];
  logic [7:0] cap_ph [`TRANS_NUM];
  // index the monitor expects next
  int next_idx;

  fpga_top u_dut (
    .CPU_CKIO(CPU_CKIO),
    .rst_n(rst_n),
    .cpu_cs_n(cpu_cs_n),
    .cpu_we_n(cpu_we_n),
    .cpu_select(cpu_select),
    .cpu_addr(cpu_addr),
    .cpu_data(cpu_data),
    .dout(dout),
    .dout_valid(dout_valid)
  );

  // 40 ns period
  initial begin
    CPU_CKIO = 1'b0;
    forever begin
      #20 CPU_CKIO = ~CPU_CKIO;
    end
  end

  `include "tb_fpga_tasks.svh"

  // output monitor, indices run 0 .. TRANS_NUM-1 and wrap
  always @(negedge CPU_CKIO) begin
    if (rst_n && dout_valid) begin
      n_checks++;
      assert (int'(dout.idx) == next_idx) else begin
        n_errors++;
        $display("Mismatch at %0t: dout.idx got %0d expected %0d",
          $time, dout.idx, next_idx);
      end
      // one index per valid output
      next_idx = (next_idx == `TRANS_NUM - 1) ? 0 : next_idx + 1;
    end
  end

  initial begin
    rst_n = 1'b0;
    cpu_cs_n = 1'b1;
    cpu_we_n = 1'b1;
    cpu_select = 2'd0;
    cpu_addr = 14'd0;
    cpu_data = 16'd0;
    n_checks = 0;
    n_errors = 0;
    timed_out = 1'b0;
    next_idx = 0;
    rng_state = 32'hc602_fa8b;
    hold_reset();
    test_frame_order();
    test_pass_through();
    test_scaling();
    test_mod_stepping();
    test_segment_switch();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
fpga_pkg.sv
seg_ram.sv
controller_regs.sv
mod_sampler.sv
gain_reader.sv
intensity_modulator.sv
fpga_top.sv
tb_fpga_top.sv
